/* design/dw_defines.svh */
`ifndef DW_DEFINES_SVH
`define DW_DEFINES_SVH

// ====================
// Datapath sizes
// ====================

// Bits per data word
`define DW_WORD_WIDTH 8

// Words per member column
`define DW_UNITS 2

// Member columns per wide input beat
`define DW_MEMBERS 12

// Per-member user word
`define DW_USER_WIDTH 8

// Wide enough to index any member
`define DW_SLOT_BITS 4

`endif

/* design/dw_cfg_pkg.sv */
`include "dw_defines.svh"

package dw_cfg_pkg;

  // Half kernel width, kw = 2*kw2 + 1
  typedef logic [2:0] kw2_t;

  // Stride minus one
  typedef logic [1:0] sw1_t;

  // Stride class j, zero when the mode is not supported
  typedef logic [`DW_SLOT_BITS-1:0] stride_class_t;

  typedef struct packed {
    logic       spare_hi;
    sw1_t       sw_1;
    kw2_t       kw2;
    logic [1:0] spare_lo;
  } dw_user_fields_t;

  // Top member user word, raw or split into mode fields
  typedef union packed {
    logic [`DW_USER_WIDTH-1:0] raw;
    dw_user_fields_t           fields;
  } dw_user_u;

  // j = kw + sw - 1
  function automatic stride_class_t stride_class(kw2_t kw2, sw1_t sw_1);
    case ({kw2, sw_1})
      {3'd0, 2'd0}: return stride_class_t'(1);
      {3'd1, 2'd0}: return stride_class_t'(3);
      {3'd2, 2'd0}: return stride_class_t'(5);
      {3'd3, 2'd1}: return stride_class_t'(8);
      default:      return stride_class_t'(0);
    endcase
  endfunction

endpackage

/* design/dw_stream_pkg.sv */
`include "dw_defines.svh"

package dw_stream_pkg;

  // ====================
  // Stream payload types
  // ====================

  // One member column with its own user word
  typedef struct packed {
    logic [`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] data;
    logic [`DW_USER_WIDTH-1:0]                user;
  } member_t;

  // Wide input beat, member 0 in the low bits
  typedef member_t [`DW_MEMBERS-1:0] beat_t;

  // One keep bit per member
  typedef logic [`DW_MEMBERS-1:0] keep_t;

endpackage

/* design/dw_beat_if.sv */
`timescale 1ns/1ps

interface dw_beat_if
  import dw_cfg_pkg::*, dw_stream_pkg::*;
  ();

  beat_t         beat;
  keep_t         keep;
  stride_class_t j;
  logic          last;
  logic          valid;
  logic          ready;

  // Input side holds the beat
  modport capture (
    output beat,
    output keep,
    output j,
    output last,
    output valid,
    input  ready
  );

  // Processing side pulls it
  modport select (
    input  beat,
    input  keep,
    input  j,
    input  last,
    input  valid,
    output ready
  );

endinterface

/* design/dw_capture.sv */
`timescale 1ns/1ps
`include "dw_defines.svh"

module dw_capture
  import dw_cfg_pkg::*, dw_stream_pkg::*;
(
  input  logic       aclk,
  input  logic       i_arst_n,
  input  beat_t      i_s_data,
  input  keep_t      i_s_keep,
  input  logic       i_s_last,
  input  logic       i_s_valid,
  output logic       o_s_ready,
  dw_beat_if.capture bo
);

  beat_t         beat_q;
  keep_t         keep_q;
  stride_class_t j_q;
  logic          last_q;
  logic          full_q;
  dw_user_u      mode;
  logic          take;

  // Layer mode rides in the top member
  assign mode.raw = i_s_data[`DW_MEMBERS-1].user;

  // Empty or emptied this cycle
  assign o_s_ready = ~full_q | bo.ready;
  assign take      = i_s_valid & o_s_ready;

  // ====================
  // Holding register
  // ====================

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (bo.ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      beat_q <= i_s_data;
      keep_q <= i_s_keep;
      last_q <= i_s_last;
      j_q    <= stride_class(mode.fields.kw2, mode.fields.sw_1);
    end
  end

  assign bo.beat  = beat_q;
  assign bo.keep  = keep_q;
  assign bo.j     = j_q;
  assign bo.last  = last_q;
  assign bo.valid = full_q;

endmodule

/* design/dw_member_select.sv */
`timescale 1ns/1ps
`include "dw_defines.svh"

module dw_member_select
  import dw_cfg_pkg::*, dw_stream_pkg::*;
(
  input  logic      aclk,
  input  logic      i_arst_n,
  dw_beat_if.select bi,
  output member_t   o_member,
  output logic      o_last,
  output logic      o_valid,
  input  logic      i_ready
);

  // Members retained for stride class j
  function automatic keep_t stride_mask(stride_class_t j);
    keep_t mask;
    int    jw;
    mask = '0;
    jw   = int'(j);
    for (int m = 0; m < `DW_MEMBERS; m++) begin
      if (jw != 0 && (m % jw) == (jw - 1)) begin
        mask[m] = 1'b1;
      end
    end
    return mask;
  endfunction

  member_t [`DW_MEMBERS-1:0] slot_q;
  member_t [`DW_MEMBERS-1:0] load_slot;
  keep_t                     slot_v_q;
  keep_t                     load_v;
  keep_t                     pick;
  logic                      last_q;
  logic                      xfer;
  logic                      load;

  // ====================
  // Selection mux
  // ====================

  assign pick = bi.keep & stride_mask(bi.j);

  // Pack picked members into the low slots, ascending
  always_comb begin
    logic [`DW_SLOT_BITS-1:0] n;
    n         = '0;
    load_slot = '0;
    load_v    = '0;
    for (int m = 0; m < `DW_MEMBERS; m++) begin
      if (pick[m]) begin
        load_slot[n] = bi.beat[m];
        load_v[n]    = 1'b1;
        n            = n + `DW_SLOT_BITS'(1);
      end
    end
  end

  // ====================
  // Drain register
  // ====================

  assign o_member = slot_q[0];
  assign o_valid  = slot_v_q[0];
  assign xfer     = slot_v_q[0] & i_ready;

  // Final valid slot of the beat
  assign o_last   = last_q & slot_v_q[0] & ~slot_v_q[1];

  // Free now, or after the last slot leaves this cycle
  assign bi.ready = ~slot_v_q[0] | (xfer & ~slot_v_q[1]);
  assign load     = bi.valid & bi.ready;

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      slot_v_q <= '0;
    end else if (load) begin
      slot_v_q <= load_v;
    end else if (xfer) begin
      slot_v_q <= slot_v_q >> 1;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      slot_q <= load_slot;
      last_q <= bi.last;
    end else if (xfer) begin
      slot_q <= slot_q >> $bits(member_t);
    end
  end

endmodule

/* design/axis_skid.sv */
`timescale 1ns/1ps

module axis_skid
  import dw_stream_pkg::*;
(
  input  logic    aclk,
  input  logic    i_arst_n,
  input  member_t i_member,
  input  logic    i_last,
  input  logic    i_valid,
  output logic    o_ready,
  output member_t o_member,
  output logic    o_last,
  output logic    o_valid,
  input  logic    i_ready
);

  member_t main_q;
  member_t skid_q;
  logic    main_last_q;
  logic    skid_last_q;
  logic    main_v_q;
  logic    skid_v_q;
  logic    in_xfer;
  logic    main_free;

  // Ready comes straight from a flop
  assign o_ready   = ~skid_v_q;
  assign in_xfer   = i_valid & ~skid_v_q;
  assign main_free = ~main_v_q | i_ready;

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      main_v_q <= 1'b0;
      skid_v_q <= 1'b0;
    end else if (main_free) begin
      main_v_q <= skid_v_q | in_xfer;
      skid_v_q <= 1'b0;
    end else if (in_xfer) begin
      skid_v_q <= 1'b1;
    end
  end

  // Skid entry drains first
  always_ff @(posedge aclk) begin
    if (main_free) begin
      if (skid_v_q) begin
        main_q      <= skid_q;
        main_last_q <= skid_last_q;
      end else begin
        main_q      <= i_member;
        main_last_q <= i_last;
      end
    end
    if (!skid_v_q) begin
      skid_q      <= i_member;
      skid_last_q <= i_last;
    end
  end

  assign o_member = main_q;
  assign o_last   = main_last_q;
  assign o_valid  = main_v_q;

endmodule

/* design/axis_dw_shift.sv */
`timescale 1ns/1ps
`include "dw_defines.svh"

module axis_dw_shift
  import dw_stream_pkg::*;
(
  input  logic                                     aclk,
  input  logic                                     i_arst_n,
  input  beat_t                                    i_s_data,
  input  keep_t                                    i_s_keep,
  input  logic                                     i_s_last,
  input  logic                                     i_s_valid,
  output logic                                     o_s_ready,
  output logic [`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] o_m_data,
  output logic [`DW_USER_WIDTH-1:0]                o_m_user,
  output logic                                     o_m_last,
  output logic                                     o_m_valid,
  input  logic                                     i_m_ready
);

  member_t sel_member;
  logic    sel_last;
  logic    sel_valid;
  logic    sel_ready;
  member_t m_member;

  dw_beat_if beat_link ();

  dw_capture u_capture (
    .aclk      (aclk),
    .i_arst_n  (i_arst_n),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .i_s_last  (i_s_last),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .bo        (beat_link)
  );

  dw_member_select u_select (
    .aclk     (aclk),
    .i_arst_n (i_arst_n),
    .bi       (beat_link),
    .o_member (sel_member),
    .o_last   (sel_last),
    .o_valid  (sel_valid),
    .i_ready  (sel_ready)
  );

  // Output slice
  axis_skid u_skid (
    .aclk     (aclk),
    .i_arst_n (i_arst_n),
    .i_member (sel_member),
    .i_last   (sel_last),
    .i_valid  (sel_valid),
    .o_ready  (sel_ready),
    .o_member (m_member),
    .o_last   (o_m_last),
    .o_valid  (o_m_valid),
    .i_ready  (i_m_ready)
  );

  assign o_m_data = m_member.data;
  assign o_m_user = m_member.user;

endmodule

/* test/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns are mode code, keep, last, data seed
typedef struct packed {
  logic [7:0] mode;
  keep_t      keep;
  logic       last;
  logic [7:0] seed;
} vec_t;

localparam int NUM_VECTORS = 12;

localparam vec_t VECTORS [NUM_VECTORS] = '{
  '{8'h00, 12'hfff, 1'b1, 8'h10},
  '{8'h00, 12'hfff, 1'b0, 8'h20},
  '{8'h04, 12'hfff, 1'b1, 8'h30},
  '{8'h08, 12'hfff, 1'b1, 8'h40},
  '{8'h2c, 12'hfff, 1'b1, 8'h50},
  '{8'h04, 12'hedf, 1'b1, 8'h60},
  '{8'h2c, 12'hf7f, 1'b0, 8'h70},
  '{8'h10, 12'hfff, 1'b0, 8'h80},
  '{8'h4c, 12'hfff, 1'b0, 8'h90},
  '{8'h00, 12'ha5a, 1'b1, 8'ha0},
  '{8'h08, 12'h210, 1'b1, 8'hb0},
  '{8'h00, 12'h001, 1'b1, 8'hc0}
};

`endif

/* test/tb_axis_dw_shift.sv */
`timescale 1ns/1ps
`include "dw_defines.svh"

module tb_axis_dw_shift
  import dw_cfg_pkg::*, dw_stream_pkg::*;
();

  `include "tb_vectors.svh"

  localparam int TIMEOUT_CYCLES = 2000;

  logic                                     aclk;
  logic                                     i_arst_n;
  beat_t                                    i_s_data;
  keep_t                                    i_s_keep;
  logic                                     i_s_last;
  logic                                     i_s_valid;
  logic                                     o_s_ready;
  logic [`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] o_m_data;
  logic [`DW_USER_WIDTH-1:0]                o_m_user;
  logic                                     o_m_last;
  logic                                     o_m_valid;
  logic                                     i_m_ready;

  member_t exp_members [$];
  logic    exp_lasts [$];
  member_t got_member;
  logic    random_ready;

  axis_dw_shift i_dut (
    .aclk      (aclk),
    .i_arst_n  (i_arst_n),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .i_s_last  (i_s_last),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .o_m_data  (o_m_data),
    .o_m_user  (o_m_user),
    .o_m_last  (o_m_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready)
  );

  always #2 aclk = ~aclk;

  // ====================
  // Checks
  // ====================

  task automatic stop_with_error(string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_member(string name, member_t got, member_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_last(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // ====================
  // Reference model
  // ====================

  // kw = 2*kw2 + 1, sw = sw_1 + 1, j = kw + sw - 1 for the supported pairs
  function automatic stride_class_t expected_stride(logic [7:0] code);
    dw_user_u u;
    int       kw;
    int       sw;
    u.raw = code;
    kw    = 2 * int'(u.fields.kw2) + 1;
    sw    = int'(u.fields.sw_1) + 1;
    if ((kw <= 5 && sw == 1) || (kw == 7 && sw == 2)) begin
      return stride_class_t'(kw + sw - 1);
    end
    return stride_class_t'(0);
  endfunction

  // Mode code only in the top member
  function automatic beat_t build_beat(vec_t v);
    beat_t b;
    for (int m = 0; m < `DW_MEMBERS; m++) begin
      for (int u = 0; u < `DW_UNITS; u++) begin
        b[m].data[u] = v.seed + 8'(16 * m + u);
      end
      b[m].user = (m == `DW_MEMBERS - 1) ? v.mode : (v.seed ^ 8'(m + 1));
    end
    return b;
  endfunction

  task automatic queue_expected(vec_t v);
    beat_t   b;
    int      j;
    member_t picked [$];
    b = build_beat(v);
    j = int'(expected_stride(v.mode));
    for (int m = 0; m < `DW_MEMBERS; m++) begin
      if (j != 0 && (m % j) == (j - 1) && v.keep[m]) begin
        picked.push_back(b[m]);
      end
    end
    foreach (picked[i]) begin
      exp_members.push_back(picked[i]);
      exp_lasts.push_back(v.last && (i == picked.size() - 1));
    end
  endtask

  // ====================
  // Driver and monitor
  // ====================

  // Called at a rising edge, returns at the edge of the transfer
  task automatic send_beat(vec_t v);
    int waited;
    #0.5;
    i_s_data  = build_beat(v);
    i_s_keep  = v.keep;
    i_s_last  = v.last;
    i_s_valid = 1'b1;
    queue_expected(v);
    waited = 0;
    while (!o_s_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_with_error("input beat was not accepted before the timeout");
      end
      @(posedge aclk);
      #0.5;
    end
    @(posedge aclk);
  endtask

  always @(posedge aclk) begin
    #0.5;
    if (random_ready) begin
      i_m_ready = ($urandom % 3) != 0;
    end else begin
      i_m_ready = 1'b1;
    end
  end

  // Sampled mid-cycle where outputs are settled
  always @(negedge aclk) begin
    if (i_arst_n && o_m_valid && i_m_ready) begin
      if (exp_members.size() == 0) begin
        stop_with_error("output member arrived while nothing was expected");
      end
      got_member.data = o_m_data;
      got_member.user = o_m_user;
      check_member("o_m_data/o_m_user", got_member, exp_members.pop_front());
      check_last("o_m_last", o_m_last, exp_lasts.pop_front());
    end
  end

  initial begin
    int seed_init;
    int waited;
    aclk         = 1'b0;
    i_arst_n     = 1'b0;
    i_s_data     = '0;
    i_s_keep     = '0;
    i_s_last     = 1'b0;
    i_s_valid    = 1'b0;
    i_m_ready    = 1'b1;
    random_ready = 1'b0;
    seed_init    = $urandom(50310);

    repeat (5) @(posedge aclk);
    #0.5;
    i_arst_n = 1'b1;

    // Idle after reset
    repeat (4) begin
      @(negedge aclk);
      check_flag("o_m_valid", o_m_valid, 1'b0);
      check_flag("o_s_ready", o_s_ready, 1'b1);
    end
    @(posedge aclk);

    // Second pass adds random back-pressure
    for (int pass = 0; pass < 2; pass++) begin
      random_ready = (pass == 1);
      for (int i = 0; i < NUM_VECTORS; i++) begin
        send_beat(VECTORS[i]);
      end
    end
    #0.5;
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;

    waited = 0;
    while (exp_members.size() != 0) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_with_error("expected output members were still pending at the timeout");
      end
      @(posedge aclk);
    end
    repeat (20) @(posedge aclk);

    // Pipeline empty again once everything has drained
    @(negedge aclk);
    check_flag("o_m_valid", o_m_valid, 1'b0);
    check_flag("o_s_ready", o_s_ready, 1'b1);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+design
+incdir+test
design/dw_cfg_pkg.sv
design/dw_stream_pkg.sv
design/dw_beat_if.sv
design/dw_capture.sv
design/dw_member_select.sv
design/axis_skid.sv
design/axis_dw_shift.sv
test/tb_axis_dw_shift.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= tb_axis_dw_shift
RTL_TOP    ?= axis_dw_shift
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing
LINT_FLAGS ?= --lint-only
PASS_MSG   ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/$(TB_TOP):
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: $(BUILD_DIR)/$(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
